//--- classifier_config.svh
`ifndef CLASSIFIER_CONFIG_SVH
`define CLASSIFIER_CONFIG_SVH

// datapath widths and counts
`define CLS_TUPLE_BITS      104
`define CLS_RULE_ID_BITS    11
`define CLS_SEG_BITS        4
`define CLS_IDX_BITS        4
`define CLS_GROUP_NUM       2
`define CLS_STAGE_NUM       4
`define CLS_STAGE_SEL_BITS  2
`define CLS_GROUP_SEL_BITS  1

// wishbone slave port
`define CLS_WB_DATA_BITS    64
`define CLS_WB_ADDR_BITS    12

// write address map
`define CLS_ADR_TBL_HI      11
`define CLS_ADR_TBL_LO      10
`define CLS_ADR_STAGE_HI    9
`define CLS_ADR_STAGE_LO    8
`define CLS_ADR_GROUP       7
`define CLS_ADR_INDEX_HI    3
`define CLS_ADR_INDEX_LO    0

`endif

//--- classifier_pkg.sv
`default_nettype none

`include "classifier_config.svh"

package classifier_pkg;

  // five-tuple as it arrives, src_ip in the top bits
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [7:0]  proto;
  } tuple_t;

  // write opcode, taken from the table select address bits
  typedef enum logic [1:0] {
    TBL_SEGMENT = 2'd0,
    TBL_RULE    = 2'd1
  } table_sel_e;

  // which tuple port a rule range applies to
  typedef enum logic {
    PORT_DST = 1'b0,
    PORT_SRC = 1'b1
  } port_sel_e;

  // one linked rule list entry, loaded from the low data bits
  typedef struct packed {
    logic                         valid;
    logic                         has_next;
    logic [`CLS_RULE_ID_BITS-1:0] rule_id;
    port_sel_e                    port_sel;
    logic [7:0]                   proto;
    logic [15:0]                  port_lo;
    logic [15:0]                  port_hi;
    logic [`CLS_IDX_BITS-1:0]     next_index;
  } rule_entry_t;

  // segment entry, one list head per group
  typedef struct packed {
    logic                                          valid;
    logic [`CLS_GROUP_NUM-1:0][`CLS_IDX_BITS-1:0]  start_index;
  } seg_entry_t;

  typedef struct packed {
    logic                     active;
    logic [`CLS_IDX_BITS-1:0] index;
  } search_slot_t;

  typedef struct packed {
    logic                         hit;
    logic [`CLS_RULE_ID_BITS-1:0] rule_id;
  } group_result_t;

  // decoded wishbone write, broadcast to all tables
  typedef struct packed {
    logic                           en;
    table_sel_e                     sel;
    logic [`CLS_STAGE_SEL_BITS-1:0] stage;
    logic [`CLS_GROUP_SEL_BITS-1:0] group;
    logic [`CLS_IDX_BITS-1:0]       index;
    logic [`CLS_WB_DATA_BITS-1:0]   data;
  } table_write_t;

  // pipeline word passed from stage to stage
  typedef struct packed {
    logic                                 valid;
    tuple_t                               tuple;
    search_slot_t  [`CLS_GROUP_NUM-1:0]   slot;
    group_result_t [`CLS_GROUP_NUM-1:0]   result;
  } stage_bus_t;

endpackage

`default_nettype wire

//--- table_loader.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_config.svh"

module table_loader
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [`CLS_WB_ADDR_BITS-1:0]  wb_adr,
  input  logic [`CLS_WB_DATA_BITS-1:0]  wb_dat,
  output logic                          wb_ack,
  output classifier_pkg::table_write_t  tbl_wr
);

  import classifier_pkg::*;

  logic         req;
  table_write_t wr_next;

  // strobe not yet answered; ack is never held two cycles
  assign req = wb_cyc && wb_stb && !wb_ack;

  // split the address into table, stage, group and entry
  always_comb
  begin
    wr_next.en    = req && wb_we;
    wr_next.sel   = table_sel_e'(wb_adr[`CLS_ADR_TBL_HI:`CLS_ADR_TBL_LO]);
    wr_next.stage = wb_adr[`CLS_ADR_STAGE_HI:`CLS_ADR_STAGE_LO];
    wr_next.group = wb_adr[`CLS_ADR_GROUP];
    wr_next.index = wb_adr[`CLS_ADR_INDEX_HI:`CLS_ADR_INDEX_LO];
    wr_next.data  = wb_dat;
  end

  // ack and write pulse leave in the same cycle
  always_ff @(posedge clk)
  begin
    tbl_wr <= wr_next;
    if (reset)
    begin
      wb_ack    <= 1'b0;
      tbl_wr.en <= 1'b0;
    end
    else
    begin
      wb_ack <= req;
    end
  end

endmodule

`default_nettype wire

//--- segment_lookup.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_config.svh"

module segment_lookup
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          in_valid,
  input  classifier_pkg::tuple_t        in_tuple,
  input  classifier_pkg::table_write_t  tbl_wr,
  output classifier_pkg::stage_bus_t    out_bus
);

  import classifier_pkg::*;

  localparam int SEG_DEPTH = 1 << `CLS_SEG_BITS;
  localparam int NIBBLES   = $bits(in_tuple.src_ip) / `CLS_SEG_BITS;

  seg_entry_t               seg_mem [SEG_DEPTH];
  seg_entry_t               seg;
  logic [`CLS_SEG_BITS-1:0] seg_num;
  stage_bus_t               next_bus;

  // segment writes carry the segment number in the index field
  always_ff @(posedge clk)
  begin
    if (tbl_wr.en && tbl_wr.sel == TBL_SEGMENT)
    begin
      seg_mem[tbl_wr.index] <= seg_entry_t'(tbl_wr.data[$bits(seg_entry_t)-1:0]);
    end
  end

  // fold the source address nibble by nibble
  always_comb
  begin
    seg_num = '0;
    for (int n = 0; n < NIBBLES; n++)
    begin
      seg_num = seg_num ^ in_tuple.src_ip[n*`CLS_SEG_BITS +: `CLS_SEG_BITS];
    end
  end

  assign seg = seg_mem[seg_num];

  // an invalid segment leaves every group without a search
  always_comb
  begin
    next_bus.valid = in_valid;
    next_bus.tuple = in_tuple;
    for (int g = 0; g < `CLS_GROUP_NUM; g++)
    begin
      next_bus.slot[g].active = seg.valid;
      next_bus.slot[g].index  = seg.start_index[g];
      next_bus.result[g]      = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    out_bus <= next_bus;
    if (reset)
    begin
      out_bus.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rule_search_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_config.svh"

module rule_search_stage
#(
  parameter int STAGE_ID = 0
)
(
  input  logic                          clk,
  input  logic                          reset,
  input  classifier_pkg::table_write_t  tbl_wr,
  input  classifier_pkg::stage_bus_t    in_bus,
  output classifier_pkg::stage_bus_t    out_bus
);

  import classifier_pkg::*;

  localparam int DEPTH = 1 << `CLS_IDX_BITS;
  localparam logic [`CLS_STAGE_SEL_BITS-1:0] STAGE_SEL = `CLS_STAGE_SEL_BITS'(STAGE_ID);

  // one rule memory per group
  rule_entry_t               rule_mem [`CLS_GROUP_NUM][DEPTH];
  rule_entry_t               entry    [`CLS_GROUP_NUM];
  logic [15:0]               port     [`CLS_GROUP_NUM];
  logic [`CLS_GROUP_NUM-1:0] hit;
  stage_bus_t                next_bus;

  // the write names this stage, the group picks the memory
  always_ff @(posedge clk)
  begin
    if (tbl_wr.en && tbl_wr.sel == TBL_RULE && tbl_wr.stage == STAGE_SEL)
    begin
      rule_mem[tbl_wr.group][tbl_wr.index] <=
        rule_entry_t'(tbl_wr.data[$bits(rule_entry_t)-1:0]);
    end
  end

  always_comb
  begin
    next_bus = in_bus;
    for (int g = 0; g < `CLS_GROUP_NUM; g++)
    begin
      entry[g] = rule_mem[g][in_bus.slot[g].index];

      // range check on the port the rule selects
      if (entry[g].port_sel == PORT_SRC)
      begin
        port[g] = in_bus.tuple.src_port;
      end
      else
      begin
        port[g] = in_bus.tuple.dst_port;
      end

      hit[g] = in_bus.slot[g].active && entry[g].valid &&
               entry[g].proto == in_bus.tuple.proto &&
               port[g] >= entry[g].port_lo && port[g] <= entry[g].port_hi;

      // keep the larger rule ID seen so far in this group
      if (hit[g] && (!in_bus.result[g].hit ||
                     entry[g].rule_id > in_bus.result[g].rule_id))
      begin
        next_bus.result[g].hit     = 1'b1;
        next_bus.result[g].rule_id = entry[g].rule_id;
      end

      // follow the list only while entries chain on
      next_bus.slot[g].active = in_bus.slot[g].active && entry[g].valid &&
                                entry[g].has_next;
      next_bus.slot[g].index  = entry[g].next_index;
    end
  end

  always_ff @(posedge clk)
  begin
    out_bus <= next_bus;
    if (reset)
    begin
      out_bus.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- priority_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_config.svh"

module priority_select
(
  input  logic                          clk,
  input  logic                          reset,
  input  classifier_pkg::stage_bus_t    in_bus,
  output logic                          out_valid,
  output logic                          out_match,
  output logic [`CLS_RULE_ID_BITS-1:0]  out_rule_id
);

  import classifier_pkg::*;

  group_result_t best;

  // highest rule ID wins, zero when nothing hit
  always_comb
  begin
    best = '0;
    for (int g = 0; g < `CLS_GROUP_NUM; g++)
    begin
      if (in_bus.result[g].hit && (!best.hit || in_bus.result[g].rule_id > best.rule_id))
      begin
        best = in_bus.result[g];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    out_rule_id <= best.rule_id;
    if (reset)
    begin
      out_valid <= 1'b0;
      out_match <= 1'b0;
    end
    else
    begin
      out_valid <= in_bus.valid;
      out_match <= in_bus.valid && best.hit;
    end
  end

endmodule

`default_nettype wire

//--- classifier_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_config.svh"

module classifier_top
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          in_valid,
  input  classifier_pkg::tuple_t        in_tuple,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [`CLS_WB_ADDR_BITS-1:0]  wb_adr,
  input  logic [`CLS_WB_DATA_BITS-1:0]  wb_dat,
  output logic                          wb_ack,
  output logic                          out_valid,
  output logic                          out_match,
  output logic [`CLS_RULE_ID_BITS-1:0]  out_rule_id
);

  import classifier_pkg::*;

  // one write pulse seen by every table
  table_write_t tbl_wr;

  // chain[0] leaves the segment lookup, chain[s+1] leaves search stage s
  stage_bus_t   chain [`CLS_STAGE_NUM+1];

  table_loader loader
  (
    .clk    (clk),
    .reset  (reset),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_we  (wb_we),
    .wb_adr (wb_adr),
    .wb_dat (wb_dat),
    .wb_ack (wb_ack),
    .tbl_wr (tbl_wr)
  );

  segment_lookup seg_lookup
  (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_tuple (in_tuple),
    .tbl_wr   (tbl_wr),
    .out_bus  (chain[0])
  );

  for (genvar s = 0; s < `CLS_STAGE_NUM; s++)
  begin : search_gen
    rule_search_stage #(.STAGE_ID(s)) search
    (
      .clk     (clk),
      .reset   (reset),
      .tbl_wr  (tbl_wr),
      .in_bus  (chain[s]),
      .out_bus (chain[s+1])
    );
  end

  priority_select prio
  (
    .clk         (clk),
    .reset       (reset),
    .in_bus      (chain[`CLS_STAGE_NUM]),
    .out_valid   (out_valid),
    .out_match   (out_match),
    .out_rule_id (out_rule_id)
  );

endmodule

`default_nettype wire

//--- classifier_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_config.svh"

module classifier_checker
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          in_valid,
  input  classifier_pkg::tuple_t        in_tuple,
  input  logic                          exp_match,
  input  logic [`CLS_RULE_ID_BITS-1:0]  exp_rule_id,
  input  int                            row_tag,
  input  logic [8*32-1:0]               row_label,
  input  logic                          wb_cyc,
  input  logic                          wb_we,
  input  logic [`CLS_WB_ADDR_BITS-1:0]  wb_adr,
  input  logic [`CLS_WB_DATA_BITS-1:0]  wb_dat,
  input  logic                          wb_ack,
  input  logic                          out_valid,
  input  logic                          out_match,
  input  logic [`CLS_RULE_ID_BITS-1:0]  out_rule_id,
  output int                            errors,
  output int                            checks,
  output int                            pending
);

  import classifier_pkg::*;

  localparam int LATENCY = `CLS_STAGE_NUM + 2;

  typedef struct {
    int              cycle;
    int              tag;
    logic [8*32-1:0] label;
    logic            match;
    logic [10:0]     rule_id;
  } expect_t;

  // rule entries keep bits 57..0 and segment entries bits 8..0 as written
  logic [57:0] rule_shadow [`CLS_STAGE_NUM][`CLS_GROUP_NUM][16];
  logic [8:0]  seg_shadow  [16];
  expect_t     in_flight [$];
  int          cycle;

  // write request seen on the previous edge
  logic                         wr_req;
  logic [`CLS_WB_ADDR_BITS-1:0] wr_adr;
  logic [`CLS_WB_DATA_BITS-1:0] wr_dat;

  // walk every group list through all stages and keep the largest hit
  function automatic logic [11:0] predict(input tuple_t t);
    logic [3:0]  seg;
    logic [8:0]  se;
    logic [57:0] e;
    logic [15:0] port;
    logic [3:0]  idx;
    logic        active;
    logic        found;
    logic [10:0] best;
    seg = '0;
    for (int n = 0; n < 8; n++)
    begin
      seg = seg ^ t.src_ip[4*n +: 4];
    end
    se = seg_shadow[seg];
    found = 1'b0;
    best = '0;
    for (int g = 0; g < `CLS_GROUP_NUM; g++)
    begin
      active = se[8];
      idx = se[4*g +: 4];
      for (int s = 0; s < `CLS_STAGE_NUM; s++)
      begin
        e = rule_shadow[s][g][idx];
        port = e[44] ? t.src_port : t.dst_port;
        if (active && e[57] && e[43:36] == t.proto && port >= e[35:20] && port <= e[19:4])
        begin
          if (!found || e[55:45] > best)
          begin
            best = e[55:45];
          end
          found = 1'b1;
        end
        active = active && e[57] && e[56];
        idx = e[3:0];
      end
    end
    return {found, best};
  endfunction

  initial
  begin
    errors = 0;
    checks = 0;
    pending = 0;
    cycle = 0;
    wr_req = 1'b0;
    wr_adr = '0;
    wr_dat = '0;
    foreach (seg_shadow[i])
    begin
      seg_shadow[i] = '0;
    end
    foreach (rule_shadow[s, g, i])
    begin
      rule_shadow[s][g][i] = '0;
    end
  end

  always @(posedge clk)
  begin : watch
    expect_t     item;
    logic [11:0] p;
    cycle++;
    // an ack completes the write request of the edge before
    if (wb_ack && wr_req)
    begin
      if (wr_adr[11:10] == 2'd0)
      begin
        seg_shadow[wr_adr[3:0]] = wr_dat[8:0];
      end
      else if (wr_adr[11:10] == 2'd1)
      begin
        rule_shadow[wr_adr[9:8]][wr_adr[7]][wr_adr[3:0]] = wr_dat[57:0];
      end
    end
    wr_req = wb_cyc && wb_we && !wb_ack;
    wr_adr = wb_adr;
    wr_dat = wb_dat;
    if (out_valid)
    begin
      if (in_flight.size() == 0)
      begin
        $display("%0t: out_valid seen with no tuple in flight", $time);
        errors++;
      end
      else
      begin
        item = in_flight.pop_front();
        checks++;
        if (cycle - item.cycle != LATENCY)
        begin
          $display("%0t: row %0d result came after %0d cycles instead of %0d",
                   $time, item.tag, cycle - item.cycle, LATENCY);
          errors++;
        end
        if (out_match !== item.match)
        begin
          $display("[FAIL] %0t out_match expected %0b got %0b (row %0d %0s)",
                   $time, item.match, out_match, item.tag, item.label);
          errors++;
        end
        if (out_rule_id !== item.rule_id)
        begin
          $display("[FAIL] %0t out_rule_id expected %0d got %0d (row %0d %0s)",
                   $time, item.rule_id, out_rule_id, item.tag, item.label);
          errors++;
        end
      end
    end
    if (in_flight.size() > 0 && cycle - in_flight[0].cycle > LATENCY)
    begin
      item = in_flight.pop_front();
      $display("%0t: no out_valid for row %0d %0s", $time, item.tag, item.label);
      errors++;
    end
    if (in_valid && !reset)
    begin
      p = predict(in_tuple);
      if (p[11] !== exp_match || p[10:0] !== exp_rule_id)
      begin
        $display("%0t: row %0d table expects %0b/%0d but the rules give %0b/%0d",
                 $time, row_tag, exp_match, exp_rule_id, p[11], p[10:0]);
        errors++;
      end
      item.cycle = cycle;
      item.tag = row_tag;
      item.label = row_label;
      item.match = p[11];
      item.rule_id = p[10:0];
      in_flight.push_back(item);
    end
    pending = in_flight.size();
  end

endmodule

`default_nettype wire

//--- classifier_assert.sv
`timescale 1ns/1ns
`default_nettype none

module classifier_assert
(
  input logic clk,
  input logic reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic in_valid,
  input logic out_valid,
  input logic out_match
);

  // ack is a single pulse answering a strobe
  ack_after_strobe: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack without a preceding strobe");

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held longer than one cycle");

  // fixed pipeline depth: segment lookup, four stages, priority select
  valid_latency: assert property (@(posedge clk) disable iff (reset)
    out_valid == $past(in_valid, 6))
    else $error("out_valid does not follow in_valid by 6 cycles");

  match_needs_valid: assert property (@(posedge clk) disable iff (reset)
    !out_valid |-> !out_match)
    else $error("out_match high while out_valid is low");

endmodule

bind classifier_top classifier_assert protocol_assert
(
  .clk       (clk),
  .reset     (reset),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .out_match (out_match)
);

`default_nettype wire

//--- classifier_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_config.svh"

module classifier_tb;

  import classifier_pkg::*;

  localparam int NUM_ROWS = 18;
  // 144 clearing writes plus 13 rule and segment writes and one read
  localparam int NUM_WB = 158;
  localparam int WATCHDOG_NS = (NUM_WB * 4 + 2 * NUM_ROWS + 20) * 40;

  typedef struct {
    logic [31:0]     src_ip;
    logic [7:0]      proto;
    logic [15:0]     src_port;
    logic [15:0]     dst_port;
    bit              rnd_src;
    bit              rnd_dst;
    logic            match;
    logic [10:0]     rule_id;
    logic [8*32-1:0] label;
  } row_t;

  logic                         clk;
  logic                         reset;
  logic                         in_valid;
  tuple_t                       in_tuple;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [`CLS_WB_ADDR_BITS-1:0] wb_adr;
  logic [`CLS_WB_DATA_BITS-1:0] wb_dat;
  logic                         wb_ack;
  logic                         out_valid;
  logic                         out_match;
  logic [`CLS_RULE_ID_BITS-1:0] out_rule_id;
  logic                         exp_match;
  logic [`CLS_RULE_ID_BITS-1:0] exp_rule_id;
  int                           row_tag;
  logic [8*32-1:0]              row_label;
  int                           chk_errors;
  int                           chk_checks;
  int                           pending;
  int                           tb_errors;
  logic [31:0]                  lfsr;
  row_t                         rows [NUM_ROWS];

  classifier_top DUT
  (
    .clk (clk), .reset (reset), .in_valid (in_valid), .in_tuple (in_tuple),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat (wb_dat), .wb_ack (wb_ack), .out_valid (out_valid),
    .out_match (out_match), .out_rule_id (out_rule_id)
  );

  classifier_checker result_check
  (
    .clk (clk), .reset (reset), .in_valid (in_valid), .in_tuple (in_tuple),
    .exp_match (exp_match), .exp_rule_id (exp_rule_id), .row_tag (row_tag),
    .row_label (row_label),
    .wb_cyc (wb_cyc), .wb_we (wb_we), .wb_adr (wb_adr), .wb_dat (wb_dat),
    .wb_ack (wb_ack), .out_valid (out_valid), .out_match (out_match),
    .out_rule_id (out_rule_id), .errors (chk_errors), .checks (chk_checks),
    .pending (pending)
  );

  always #20 clk = ~clk;

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic        fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [11:0] rule_adr(input logic [1:0] stage, input logic grp,
                                           input logic [3:0] idx);
    return {2'd1, stage, grp, 3'b000, idx};
  endfunction

  function automatic logic [11:0] seg_adr(input logic [3:0] seg);
    return {2'd0, 2'd0, 1'b0, 3'b000, seg};
  endfunction

  function automatic logic [63:0] rule_word(input logic has_next, input logic [10:0] id,
    input logic src, input logic [7:0] proto, input logic [15:0] lo, input logic [15:0] hi,
    input logic [3:0] nxt);
    return {6'd0, 1'b1, has_next, id, src, proto, lo, hi, nxt};
  endfunction

  function automatic logic [63:0] seg_word(input logic [3:0] start0, input logic [3:0] start1);
    return {55'd0, 1'b1, start1, start0};
  endfunction

  task automatic wb_access(input logic we, input logic [11:0] adr, input logic [63:0] dat);
    int waited;
    waited = 0;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat = dat;
    @(negedge clk);
    while (!wb_ack && waited < 8)
    begin
      @(negedge clk);
      waited++;
    end
    if (!wb_ack)
    begin
      $display("%0t: wishbone cycle at address %h was never acked", $time, adr);
      tb_errors++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic load_tables();
    for (int i = 0; i < 16; i++)
    begin
      wb_access(1'b1, seg_adr(i[3:0]), '0);
    end
    for (int s = 0; s < 4; s++)
    begin
      for (int g = 0; g < 2; g++)
      begin
        for (int i = 0; i < 16; i++)
        begin
          wb_access(1'b1, rule_adr(s[1:0], g[0], i[3:0]), '0);
        end
      end
    end
    // single group rule
    wb_access(1'b1, rule_adr(0, 0, 2), rule_word(0, 100, 0, 6, 80, 90, 0));
    // group 0 chain 3 -> 4 -> 7 that ends before stage 3
    wb_access(1'b1, rule_adr(0, 0, 3), rule_word(1, 200, 0, 17, 1000, 2000, 4));
    wb_access(1'b1, rule_adr(1, 0, 4), rule_word(1, 300, 0, 17, 1500, 1600, 7));
    wb_access(1'b1, rule_adr(2, 0, 7), rule_word(0, 50, 0, 17, 0, 16'hffff, 0));
    wb_access(1'b1, rule_adr(3, 0, 0), rule_word(0, 900, 0, 17, 0, 16'hffff, 0));
    // both groups
    wb_access(1'b1, rule_adr(0, 0, 6), rule_word(0, 400, 0, 6, 0, 1023, 0));
    wb_access(1'b1, rule_adr(0, 1, 6), rule_word(1, 700, 0, 6, 20, 25, 1));
    wb_access(1'b1, rule_adr(1, 1, 1), rule_word(0, 350, 0, 6, 0, 100, 0));
    // source port rule
    wb_access(1'b1, rule_adr(0, 0, 8), rule_word(0, 555, 1, 17, 5000, 5010, 0));
    wb_access(1'b1, seg_adr(1), seg_word(2, 5));
    wb_access(1'b1, seg_adr(2), seg_word(3, 0));
    wb_access(1'b1, seg_adr(3), seg_word(6, 6));
    wb_access(1'b1, seg_adr(4), seg_word(8, 9));
  endtask

  task automatic fill_rows();
    rows[0]  = '{32'h12300123, 6, 0, 0, 1, 1, 0, 0, "invalid segment 0"};
    rows[1]  = '{32'h00000009, 17, 0, 0, 1, 1, 0, 0, "unset segment 9"};
    rows[2]  = '{32'h0A0A0001, 6, 0, 85, 1, 0, 1, 100, "single group hit"};
    rows[3]  = '{32'h0A0A0001, 6, 0, 80, 1, 0, 1, 100, "low range edge"};
    rows[4]  = '{32'h0A0A0001, 6, 0, 90, 1, 0, 1, 100, "high range edge"};
    rows[5]  = '{32'h0A0A0001, 6, 0, 91, 1, 0, 0, 0, "one above range"};
    rows[6]  = '{32'h0A0A0001, 6, 0, 79, 1, 0, 0, 0, "one below range"};
    rows[7]  = '{32'h0A0A0001, 17, 0, 85, 1, 0, 0, 0, "wrong protocol"};
    rows[8]  = '{32'h0A0A0002, 17, 0, 1550, 1, 0, 1, 300, "deeper larger id"};
    rows[9]  = '{32'h0A0A0002, 17, 0, 1100, 1, 0, 1, 200, "stage 0 id beats tail"};
    rows[10] = '{32'h0A0A0002, 17, 0, 3000, 1, 0, 1, 50, "chain end hides stage 3"};
    rows[11] = '{32'h0A0A0002, 6, 0, 1550, 1, 0, 0, 0, "chain wrong protocol"};
    rows[12] = '{32'hC0C00003, 6, 0, 22, 1, 0, 1, 700, "both hit, group 1 larger"};
    rows[13] = '{32'hC0C00003, 6, 0, 50, 1, 0, 1, 400, "both hit, group 0 larger"};
    rows[14] = '{32'hC0C00003, 6, 0, 2000, 1, 0, 0, 0, "both groups miss"};
    rows[15] = '{32'h0F0F0004, 17, 5005, 0, 0, 1, 1, 555, "source port rule"};
    rows[16] = '{32'h0F0F0004, 17, 4999, 5005, 0, 0, 0, 0, "destination port ignored"};
    rows[17] = '{32'h0F0F0004, 17, 5010, 0, 0, 1, 1, 555, "source port high edge"};
  endtask

  // one tuple per falling edge without gaps
  task automatic apply_rows();
    logic [31:0] r;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      @(negedge clk);
      r = take_bits(32);
      in_tuple.dst_ip = r;
      in_tuple.src_ip = rows[i].src_ip;
      in_tuple.proto = rows[i].proto;
      r = take_bits(16);
      in_tuple.src_port = rows[i].rnd_src ? r[15:0] : rows[i].src_port;
      r = take_bits(16);
      in_tuple.dst_port = rows[i].rnd_dst ? r[15:0] : rows[i].dst_port;
      exp_match = rows[i].match;
      exp_rule_id = rows[i].rule_id;
      row_tag = i;
      row_label = rows[i].label;
      in_valid = 1'b1;
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending != 0 && n < 20)
    begin
      @(negedge clk);
      n++;
    end
    if (pending != 0)
    begin
      $display("%0t: %0d results still missing after the pipeline drained", $time, pending);
      tb_errors++;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_tuple = '0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat = '0;
    exp_match = 1'b0;
    exp_rule_id = '0;
    row_tag = 0;
    row_label = '0;
    tb_errors = 0;
    lfsr = 32'h6649a633;
    fill_rows();
    repeat (2) @(negedge clk);
    reset = 1'b0;
    load_tables();
    apply_rows();
    wait_drain();
    // a read over a live rule must leave it intact
    wb_access(1'b0, rule_adr(0, 0, 2), '1);
    apply_rows();
    wait_drain();
    $display("results checked %0d, checker errors %0d, testbench errors %0d",
             chk_checks, chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0 && chk_checks == 2 * NUM_ROWS)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
classifier_pkg.sv
table_loader.sv
segment_lookup.sv
rule_search_stage.sv
priority_select.sv
classifier_top.sv
classifier_checker.sv
classifier_assert.sv
classifier_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the classifier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module classifier_tb -Mdir obj_dir > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vclassifier_tb > sim.log 2>&1 || echo "simulator exited with an error"

grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
